// File: field_unpack_top.f
src/unpack_pkg.sv
src/bit_fifo_if.sv
src/bit_fifo.sv
src/field_unpacker.sv
src/unpack_cmd_regs.sv
src/field_unpack_top.sv
tests/field_unpack_checker.sv
tests/field_unpack_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the field unpacker testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
   -f field_unpack_top.f --top-module field_unpack_tb -Mdir obj_dir \
   || { echo "Verilator build failed"; exit 1; }

sim_out=$(./obj_dir/Vfield_unpack_tb +verilator+error+limit+100)
echo "$sim_out"
echo "$sim_out" | grep -qx "Testbench passed" && exit 0 || exit 1

// File: src/bit_fifo.sv
`timescale 1ns/100ps

module bit_fifo import unpack_pkg::*; (
   input logic       clk_i,
   input logic       reset_i,
   bit_fifo_if.store fifo
);

   // oldest bit sits at the top of the register
   logic [FIFO_W-1:0]  data_q;
   logic [FIFO_W-1:0]  data_nxt;
   logic [LEVEL_W-1:0] level_q;
   logic [LEVEL_W-1:0] level_nxt;

   // alignment helpers
   logic [FIFO_W-1:0]  push_word;
   logic [FIFO_W-1:0]  keep_mask;
   logic [FIFO_W-1:0]  pop_word;
   logic [LEVEL_W-1:0] pop_len_ext;

   assign pop_len_ext = LEVEL_W'(fifo.pop_len);

   // new word placed at the top, then moved down below the stored bits
   assign push_word = {fifo.push_data, {(FIFO_W - PACKED_W){1'b0}}} >> level_q;

   // ones over the valid bits, so stale bits below the level are dropped
   assign keep_mask = ~({FIFO_W{1'b1}} >> level_q);

   // the top pop_len bits shifted down to the lsb end
   // zeros fill everything above the field length
   assign pop_word = data_q >> (LEVEL_W'(FIFO_W) - pop_len_ext);

   assign fifo.pop_data = pop_word[FIELD_W-1:0];
   assign fifo.level    = level_q;

   // next state
   // push and pop never come together, pop wins if they did
   always_comb begin
      data_nxt  = data_q;
      level_nxt = level_q;

      if (fifo.pop) begin
         // remove the oldest bits
         data_nxt  = data_q << pop_len_ext;
         level_nxt = level_q - pop_len_ext;
      end else if (fifo.push) begin
         // append below what is stored
         data_nxt  = (data_q & keep_mask) | push_word;
         level_nxt = level_q + LEVEL_W'(PACKED_W);
      end
   end

   // bit storage
   always_ff @(posedge clk_i) begin
      data_q <= data_nxt;
   end

   // stored bit count
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         level_q <= '0;
      end else begin
         level_q <= level_nxt;
      end
   end

endmodule

// File: src/bit_fifo_if.sv
`timescale 1ns/100ps

interface bit_fifo_if import unpack_pkg::*; ();

   // push side, always a full packed word
   logic                push;
   logic [PACKED_W-1:0] push_data;

   // pop side, variable length
   logic                pop;
   len_t                pop_len;
   logic [FIELD_W-1:0]  pop_data;

   // bits currently stored
   logic [LEVEL_W-1:0]  level;

   // push_data comes straight from the input FIFO data bus
   modport ctrl (
      output push,
      output pop,
      output pop_len,
      input  level
   );

   modport store (
      input  push, push_data, pop, pop_len,
      output pop_data, level
   );

endinterface

// File: src/field_unpack_top.sv
`timescale 1ns/100ps

module field_unpack_top import unpack_pkg::*; (
   input  logic                     clk_i,
   input  logic                     reset_i,

   // input FIFO, word arrives one cycle after the read strobe
   input  logic                     in_rready_i,
   output logic                     in_read_o,
   input  logic [PACKED_W-1:0]      in_rdata_i,

   // output FIFO
   input  logic                     out_wready_i,
   output logic                     out_write_o,
   output logic [FIELD_W-1:0]       out_wdata_o,

   // command port
   input  logic                     cmd_valid_i,
   output logic                     cmd_ready_o,
   input  cmd_op_t                  cmd_op_i,
   input  logic [$bits(len_t)-1:0]  cmd_data_i
);

   len_t len;
   logic wrap_req;
   logic wrap_done;

   bit_fifo_if fifo_if ();

   // data paths run straight between the external FIFOs and the bit FIFO
   assign fifo_if.push_data = in_rdata_i;
   assign out_wdata_o       = fifo_if.pop_data;

   bit_fifo u_bit_fifo (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .fifo    (fifo_if.store)
   );

   field_unpacker u_field_unpacker (
      .clk_i        (clk_i),
      .reset_i      (reset_i),
      .len_i        (len),
      .wrap_i       (wrap_req),
      .wrap_done_o  (wrap_done),
      .in_rready_i  (in_rready_i),
      .in_read_o    (in_read_o),
      .fifo         (fifo_if.ctrl),
      .out_wready_i (out_wready_i),
      .out_write_o  (out_write_o)
   );

   unpack_cmd_regs u_unpack_cmd_regs (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .cmd_valid_i (cmd_valid_i),
      .cmd_ready_o (cmd_ready_o),
      .cmd_op_i    (cmd_op_i),
      .cmd_data_i  (cmd_data_i),
      .len_o       (len),
      .wrap_o      (wrap_req),
      .wrap_done_i (wrap_done)
   );

endmodule

// File: src/field_unpacker.sv
`timescale 1ns/100ps

module field_unpacker import unpack_pkg::*; (
   input  logic      clk_i,
   input  logic      reset_i,

   // field length and flush request from the command block
   input  len_t      len_i,
   input  logic      wrap_i,
   output logic      wrap_done_o,

   // external input FIFO strobe
   input  logic      in_rready_i,
   output logic      in_read_o,

   // bit FIFO control
   bit_fifo_if.ctrl  fifo,

   // external output FIFO strobe
   input  logic      out_wready_i,
   output logic      out_write_o
);

   // a word has been read and sits on the input data bus
   logic               data_present_q;
   logic               data_present_nxt;

   logic [LEVEL_W-1:0] len_ext;
   logic               have_field;
   logic               have_room;

   assign len_ext    = LEVEL_W'(len_i);
   assign have_field = fifo.level >= len_ext;

   // room for one more packed word
   assign have_room  = fifo.level <= LEVEL_W'(FIFO_W - PACKED_W);

   // decide one action per cycle, pop before push
   always_comb begin
      fifo.pop         = 1'b0;
      fifo.pop_len     = len_i;
      fifo.push        = 1'b0;
      in_read_o        = 1'b0;
      out_write_o      = 1'b0;
      wrap_done_o      = 1'b0;
      data_present_nxt = data_present_q;

      if (have_field && out_wready_i) begin
         // complete field goes out this cycle
         fifo.pop    = 1'b1;
         out_write_o = 1'b1;
      end else if (wrap_i && !have_field && !data_present_q) begin
         // leftover is shorter than a field, throw it away
         // nothing to pop when the FIFO is already empty
         fifo.pop     = fifo.level != '0;
         fifo.pop_len = len_t'(fifo.level);
         wrap_done_o  = 1'b1;
      end else if (data_present_q && have_room) begin
         fifo.push = 1'b1;
         // fetch the next word right away when one is waiting
         if (in_rready_i && !wrap_i) begin
            in_read_o = 1'b1;
         end else begin
            data_present_nxt = 1'b0;
         end
      end else if (!data_present_q && in_rready_i && !wrap_i) begin
         // word shows up on the bus next cycle
         in_read_o        = 1'b1;
         data_present_nxt = 1'b1;
      end
   end

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         data_present_q <= 1'b0;
      end else begin
         data_present_q <= data_present_nxt;
      end
   end

endmodule

// File: src/unpack_cmd_regs.sv
`timescale 1ns/100ps

module unpack_cmd_regs import unpack_pkg::*; (
   input  logic                     clk_i,
   input  logic                     reset_i,

   // command port
   input  logic                     cmd_valid_i,
   output logic                     cmd_ready_o,
   input  cmd_op_t                  cmd_op_i,
   input  logic [$bits(len_t)-1:0]  cmd_data_i,

   // to the unpacker
   output len_t                     len_o,
   output logic                     wrap_o,
   input  logic                     wrap_done_i
);

   len_t len_q;
   len_t len_clamped;
   logic wrap_q;
   logic accept;

   // no new command until a pending wrap has finished
   assign cmd_ready_o = !wrap_q;
   assign accept      = cmd_valid_i && cmd_ready_o;

   // out of range lengths become the full field width
   assign len_clamped = (cmd_data_i == '0 || cmd_data_i > len_t'(FIELD_W)) ?
                        len_t'(FIELD_W) : len_t'(cmd_data_i);

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         len_q  <= LEN_RESET;
         wrap_q <= 1'b0;
      end else begin
         if (accept) begin
            case (cmd_op_i)
               CMD_SET_LEN: len_q  <= len_clamped;
               CMD_WRAP:    wrap_q <= 1'b1;
               default:     len_q  <= len_q;
            endcase
         end else if (wrap_done_i) begin
            // flush complete, accept commands again
            wrap_q <= 1'b0;
         end
      end
   end

   assign len_o  = len_q;
   assign wrap_o = wrap_q;

endmodule

// File: src/unpack_pkg.sv
package unpack_pkg;

   // width of one packed word read from the input FIFO
   localparam int PACKED_W = 32;

   // longest field, also the width of the output word
   localparam int FIELD_W = 16;

   // bit FIFO holds two of the larger word
   localparam int FIFO_W = 64;

   // bit counts run from 0 to FIFO_W
   localparam int LEVEL_W = 7;

   // field length, 1 to FIELD_W
   typedef logic [4:0] len_t;

   // command opcodes
   typedef enum logic {
      CMD_SET_LEN = 1'b0,
      CMD_WRAP    = 1'b1
   } cmd_op_t;

   // field length after reset
   localparam len_t LEN_RESET = 5'd8;

endpackage

// File: tests/field_unpack_checker.sv
`timescale 1ns/100ps

module field_unpack_checker import unpack_pkg::*; (
   input logic    clk_i,
   input logic    reset_i,
   input logic    in_rready_i,
   input logic    in_read_o,
   input logic    out_wready_i,
   input logic    out_write_o,
   input logic    cmd_valid_i,
   input logic    cmd_ready_o,
   input cmd_op_t cmd_op_i,
   input logic    wrap_req,
   input logic    wrap_done
);

   logic write_fired      = 1'b0;
   logic read_fired       = 1'b0;
   logic reset_fired      = 1'b0;
   logic wrap_start_fired = 1'b0;
   logic wrap_hold_fired  = 1'b0;
   logic wrap_end_fired   = 1'b0;
   logic any_fired;

   assign any_fired = write_fired | read_fired | reset_fired | wrap_start_fired |
                      wrap_hold_fired | wrap_end_fired;

   // strobes only toward a FIFO that can take them
   a_write_ready: assert property (@(posedge clk_i) disable iff (reset_i)
      out_write_o |-> out_wready_i)
      else begin
         $error("out_write_o asserted while out_wready_i is low");
         write_fired = 1'b1;
      end

   a_read_ready: assert property (@(posedge clk_i) disable iff (reset_i)
      in_read_o |-> in_rready_i)
      else begin
         $error("in_read_o asserted while in_rready_i is low");
         read_fired = 1'b1;
      end

   // first cycle out of reset is quiet
   a_reset_quiet: assert property (@(posedge clk_i)
      $fell(reset_i) |-> !in_read_o && !out_write_o)
      else begin
         $error("strobe asserted in the first cycle after reset");
         reset_fired = 1'b1;
      end

   // a wrap takes the command port until the flush is over
   a_wrap_start: assert property (@(posedge clk_i) disable iff (reset_i)
      cmd_valid_i && cmd_ready_o && cmd_op_i == CMD_WRAP |=> wrap_req && !cmd_ready_o)
      else begin
         $error("accepted wrap did not block the command port");
         wrap_start_fired = 1'b1;
      end

   a_wrap_hold: assert property (@(posedge clk_i) disable iff (reset_i)
      wrap_req && !wrap_done |=> wrap_req)
      else begin
         $error("wrap request dropped before the wrap finished");
         wrap_hold_fired = 1'b1;
      end

   // the dropped remainder leaves nothing behind to write
   a_wrap_end: assert property (@(posedge clk_i) disable iff (reset_i)
      wrap_done |=> !out_write_o)
      else begin
         $error("out_write_o asserted right after the wrap finished");
         wrap_end_fired = 1'b1;
      end

endmodule

// File: tests/field_unpack_tb.sv
`timescale 1ns/100ps

module field_unpack_tb import unpack_pkg::*; ();

   localparam int          TIMEOUT_CYCLES = 20000;
   localparam logic [31:0] RAND_SEED      = 32'h0d4e_255b;

   logic                clk_i        = 1'b0;
   logic                reset_i      = 1'b1;
   logic                in_rready_i  = 1'b0;
   logic                in_read_o;
   logic [PACKED_W-1:0] in_rdata_i   = '0;
   logic                out_wready_i = 1'b0;
   logic                out_write_o;
   logic [FIELD_W-1:0]  out_wdata_o;
   logic                cmd_valid_i  = 1'b0;
   logic                cmd_ready_o;
   cmd_op_t             cmd_op_i     = CMD_SET_LEN;
   logic [4:0]          cmd_data_i   = '0;

   // words still in the input FIFO
   logic [PACKED_W-1:0] in_q[$];
   // word on the data bus after the last read
   logic [PACKED_W-1:0] bus_word     = '0;
   // reference stream, oldest bit first
   logic                ref_q[$];
   len_t                model_len    = LEN_RESET;
   logic                random_ready = 1'b0;
   int                  field_count  = 0;
   int                  cycle_count  = 0;

   field_unpack_top uut (
      .clk_i        (clk_i),
      .reset_i      (reset_i),
      .in_rready_i  (in_rready_i),
      .in_read_o    (in_read_o),
      .in_rdata_i   (in_rdata_i),
      .out_wready_i (out_wready_i),
      .out_write_o  (out_write_o),
      .out_wdata_o  (out_wdata_o),
      .cmd_valid_i  (cmd_valid_i),
      .cmd_ready_o  (cmd_ready_o),
      .cmd_op_i     (cmd_op_i),
      .cmd_data_i   (cmd_data_i)
   );

   bind field_unpack_top field_unpack_checker u_checker (
      .clk_i        (clk_i),
      .reset_i      (reset_i),
      .in_rready_i  (in_rready_i),
      .in_read_o    (in_read_o),
      .out_wready_i (out_wready_i),
      .out_write_o  (out_write_o),
      .cmd_valid_i  (cmd_valid_i),
      .cmd_ready_o  (cmd_ready_o),
      .cmd_op_i     (cmd_op_i),
      .wrap_req     (wrap_req),
      .wrap_done    (wrap_done)
   );

   always #4 clk_i = ~clk_i;

   task automatic abort_run(string line);
      $display("%s", line);
      $display("Testbench failed");
      $fatal(1);
   endtask

   // 0 and anything above 16 mean a full 16 bit field
   function automatic len_t clamp_len(logic [4:0] value);
      if (value == 5'd0 || value > 5'd16) begin
         return 5'd16;
      end
      return value;
   endfunction

   // first bit taken lands in the msb of the field
   function automatic logic [FIELD_W-1:0] take_field(len_t len);
      logic [FIELD_W-1:0] field;
      field = '0;
      for (int i = 0; i < int'(len); i++) begin
         field = {field[FIELD_W-2:0], ref_q.pop_front()};
      end
      return field;
   endfunction

   // external FIFO models, driven away from the sampling edge
   always @(negedge clk_i) begin
      in_rdata_i   = bus_word;
      in_rready_i  = in_q.size() != 0 && (!random_ready || ($urandom % 4) != 0);
      out_wready_i = !random_ready || ($urandom % 2) != 0;
   end

   always @(posedge clk_i) begin : monitor
      logic [PACKED_W-1:0] word;
      logic [FIELD_W-1:0]  expected;
      if (!reset_i) begin
         cycle_count++;
         if (out_write_o) begin
            assert (ref_q.size() >= int'(model_len))
               else abort_run($sformatf("[ERROR] %0t ns: field of %0d bits with %0d bits left",
                                        $time, model_len, ref_q.size()));
            expected = take_field(model_len);
            assert (out_wdata_o == expected)
               else abort_run($sformatf("[ERROR] %0t ns: field %0d is %h, expected %h",
                                        $time, field_count, out_wdata_o, expected));
            field_count++;
         end
         if (in_read_o) begin
            assert (in_q.size() != 0)
               else abort_run("input FIFO was read while it held no word");
            word     = in_q.pop_front();
            bus_word = word;
            for (int b = PACKED_W - 1; b >= 0; b--) begin
               ref_q.push_back(word[b]);
            end
         end
         // new length counts from the next cycle
         if (cmd_valid_i && cmd_ready_o && cmd_op_i == CMD_SET_LEN) begin
            model_len = clamp_len(cmd_data_i);
         end
         if (uut.u_checker.any_fired) begin
            abort_run("a protocol assertion in the checker failed");
         end
         if (cycle_count >= TIMEOUT_CYCLES) begin
            abort_run($sformatf("timeout, the run did not finish in %0d cycles",
                                TIMEOUT_CYCLES));
         end
      end
   end

   task automatic issue_command(cmd_op_t op, logic [4:0] data);
      while (!cmd_ready_o) begin
         @(negedge clk_i);
      end
      cmd_valid_i = 1'b1;
      cmd_op_i    = op;
      cmd_data_i  = data;
      @(negedge clk_i);
      cmd_valid_i = 1'b0;
   endtask

   // all words read and every complete field written
   task automatic drain_stream();
      while (in_q.size() != 0 || ref_q.size() >= int'(model_len)) begin
         @(negedge clk_i);
      end
   endtask

   task automatic wrap_stream();
      while (in_q.size() != 0) begin
         @(negedge clk_i);
      end
      issue_command(CMD_WRAP, 5'd0);
      while (!cmd_ready_o) begin
         @(negedge clk_i);
      end
      assert (ref_q.size() < int'(model_len))
         else abort_run($sformatf("[ERROR] %0t ns: wrap ended with %0d bits unwritten",
                                  $time, ref_q.size()));
      ref_q.delete();
   endtask

   task automatic check_idle(int cycles);
      repeat (cycles) begin
         @(negedge clk_i);
         assert (!in_read_o && !out_write_o && cmd_ready_o)
            else abort_run($sformatf("[ERROR] %0t ns: idle outputs are %b%b%b, expected 001",
                                     $time, in_read_o, out_write_o, cmd_ready_o));
      end
   endtask

   initial begin : stimulus
      logic [4:0] lengths [5];
      lengths = '{5'd5, 5'd13, 5'd16, 5'd1, 5'd0};
      void'($urandom(RAND_SEED));
      reset_i = 1'b1;
      repeat (3) @(posedge clk_i);
      @(negedge clk_i);
      reset_i = 1'b0;

      check_idle(10);

      // 16 words at length 8
      issue_command(CMD_SET_LEN, 5'd8);
      repeat (16) in_q.push_back($urandom);
      drain_stream();

      // length changes between words, 0 ends up as 16
      foreach (lengths[i]) begin
         issue_command(CMD_SET_LEN, lengths[i]);
         repeat (2) in_q.push_back($urandom);
         drain_stream();
      end

      // 96 bits at length 13 leave 5 bits for the wrap to drop
      issue_command(CMD_SET_LEN, 5'd13);
      wrap_stream();
      repeat (3) in_q.push_back($urandom);
      wrap_stream();
      // fields of the next word start at its top bit
      in_q.push_back($urandom);
      drain_stream();
      wrap_stream();

      // random readiness on both FIFOs
      random_ready = 1'b1;
      for (int i = 0; i < 200; i++) begin
         in_q.push_back($urandom);
         if (i % 10 == 9) begin
            issue_command(CMD_SET_LEN, 5'($urandom % 32));
         end
         repeat ($urandom % 4) @(negedge clk_i);
      end
      drain_stream();
      wrap_stream();
      random_ready = 1'b0;

      check_idle(5);
      if (uut.u_checker.any_fired) begin
         abort_run("a protocol assertion in the checker failed");
      end else begin
         $display("Testbench passed");
         $finish;
      end
   end

endmodule
